// File: Bender.yml
package:
  name: hx8352_ctrl

sources:
  - logic/hx8352_pkg.sv
  - logic/ms_delay_timer.sv
  - logic/power_on_sequencer.sv
  - logic/host_write_framer.sv
  - logic/lcd_bus_writer.sv
  - logic/hx8352_ctrl.sv
  - target: test
    files:
      - bench/panel_bus_monitor.sv
      - bench/hx8352_ctrl_tb.sv

// File: bench/hx8352_ctrl_tb.sv
`timescale 1ns/1ps

module hx8352_ctrl_tb import hx8352_pkg::*; ();
	localparam int CLK_PERIOD  = 40;
	localparam int BURST_LEN   = 4;
	localparam int WORD_CYCLES = WR_LOW_CYCLES + WR_HIGH_CYCLES;

	logic      fsm_clk;
	logic      fsm_rst;
	host_req_t req;
	logic      req_valid;
	logic      req_ready;
	logic      init_done;
	lcd_word_t lcd_data;
	logic      lcd_rs;
	logic      lcd_wr;
	logic      lcd_cs;
	logic      lcd_rst;
	int        errors     = 0;
	int        next_word  = 0; // Next captured word to check
	int        next_frame = 0;
	time       rst_rise;
	int        init_words;
	host_req_t held;

	hx8352_ctrl uut (
		.fsm_clk   (fsm_clk),
		.fsm_rst   (fsm_rst),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.init_done (init_done),
		.lcd_data  (lcd_data),
		.lcd_rs    (lcd_rs),
		.lcd_wr    (lcd_wr),
		.lcd_cs    (lcd_cs),
		.lcd_rst   (lcd_rst)
	);

	panel_bus_monitor mon (
		.lcd_cs   (lcd_cs),
		.lcd_wr   (lcd_wr),
		.lcd_rs   (lcd_rs),
		.lcd_data (lcd_data)
	);

	initial fsm_clk = 1'b0;
	always #(CLK_PERIOD / 2) fsm_clk = ~fsm_clk;

	function automatic int pause_ms_total();
		int sum = 0;
		for (int i = 0; i < INIT_LEN; i++) begin
			if (INIT_TABLE[i].kind == INIT_DELAY) begin
				sum += int'(INIT_TABLE[i].value);
			end
		end
		return sum;
	endfunction

	function automatic int word_total();
		int n = 0;
		for (int i = 0; i < INIT_LEN; i++) begin
			if (INIT_TABLE[i].kind != INIT_DELAY) begin
				n++;
			end
		end
		return n;
	endfunction

	function automatic int watchdog_cycles();
		int host_words;
		host_words = 2 * (3 + BURST_LEN); // Held, register, pixel and burst frames
		return 2 * ((RST_LOW_MS + RST_WAIT_MS + pause_ms_total()) * MS_CYCLES
			+ (word_total() + host_words) * (WORD_CYCLES + 3) + 4 + 20);
	endfunction

	function automatic lcd_word_t cmd_word_of(input host_req_t r);
		return r.is_cmd ? {8'h00, r.code} : {8'h00, CMD_MEM_WRITE};
	endfunction

	function automatic host_req_t random_req(input logic is_cmd);
		host_req_t r;
		r.is_cmd = is_cmd;
		r.code   = cmd_code_t'($urandom); // Ignored for pixel writes
		r.data   = lcd_word_t'($urandom);
		return r;
	endfunction

	task automatic abort_run(input string why);
		errors++;
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compare_word(input int idx, input logic rs, input lcd_word_t data,
			input int frame);
		assert (mon.cap_rs[idx] == rs)
			else abort_run($sformatf("ERR lcd_rs word %0d expected %h got %h",
				idx, rs, mon.cap_rs[idx]));
		assert (mon.cap_data[idx] == data)
			else abort_run($sformatf("ERR lcd_data word %0d expected %h got %h",
				idx, data, mon.cap_data[idx]));
		assert (mon.cap_frame[idx] == frame)
			else abort_run($sformatf("ERR lcd_cs frame of word %0d expected %h got %h",
				idx, frame, mon.cap_frame[idx]));
	endtask

	task automatic wait_words(input int n, input int limit);
		int cycles = 0;
		while (mon.cap_count < n) begin
			@(negedge fsm_clk);
			cycles++;
			if (cycles > limit) begin
				abort_run($sformatf("Timed out waiting for panel word %0d", n));
			end
		end
	endtask

	task automatic send_req(input host_req_t r);
		int cycles = 0;
		req       = r;
		req_valid = 1'b1;
		while (!req_ready) begin
			@(negedge fsm_clk);
			cycles++;
			if (cycles > watchdog_cycles()) begin
				abort_run("Host request was never accepted");
			end
		end
		@(negedge fsm_clk); // Accepted on the edge before
		req_valid = 1'b0;
		assert (req_ready == 1'b0)
			else abort_run($sformatf("ERR req_ready expected %h got %h", 1'b0, req_ready));
	endtask

	task automatic match_host_frame(input host_req_t r);
		wait_words(next_word + 2, 100);
		compare_word(next_word, 1'b0, cmd_word_of(r), next_frame);
		compare_word(next_word + 1, 1'b1, r.data, next_frame);
		next_word += 2;
		next_frame++;
	endtask

	task automatic verify_reset();
		int cycles = 0;
		repeat (4) @(posedge fsm_clk);
		@(negedge fsm_clk);
		assert (lcd_rst == 1'b0) else abort_run($sformatf("ERR lcd_rst expected 0 got %h", lcd_rst));
		assert (lcd_cs == 1'b1) else abort_run($sformatf("ERR lcd_cs expected 1 got %h", lcd_cs));
		assert (lcd_wr == 1'b1) else abort_run($sformatf("ERR lcd_wr expected 1 got %h", lcd_wr));
		assert (init_done == 1'b0)
			else abort_run($sformatf("ERR init_done expected 0 got %h", init_done));
		assert (req_ready == 1'b1)
			else abort_run($sformatf("ERR req_ready expected 1 got %h", req_ready));
		fsm_rst = 1'b0;
		while (!lcd_rst) begin
			@(negedge fsm_clk);
			cycles++;
			assert (mon.cap_count == 0) else abort_run("A panel word was written during panel reset");
			if (cycles > watchdog_cycles()) begin
				abort_run("Panel reset was never released");
			end
		end
		rst_rise = $time;
		assert (cycles >= RST_LOW_MS * MS_CYCLES)
			else abort_run($sformatf("ERR lcd_rst low cycles expected >= %h got %h",
				RST_LOW_MS * MS_CYCLES, cycles));
	endtask

	task automatic hold_early_request();
		int cycles = 0;
		held = random_req(1'b1);
		send_req(held);
		while (!init_done) begin
			assert (req_ready == 1'b0) // Held in the framer during power-on
				else abort_run($sformatf("ERR req_ready expected 0 got %h", req_ready));
			@(negedge fsm_clk);
			cycles++;
			if (cycles > watchdog_cycles()) begin
				abort_run("Power-on sequence never finished");
			end
		end
		init_words = mon.cap_count;
	endtask

	task automatic compare_power_on();
		int        k = 0;
		int        f0;
		lcd_word_t exp_data;
		assert (init_words == word_total())
			else abort_run($sformatf("ERR init word count expected %h got %h",
				word_total(), init_words));
		f0 = mon.cap_frame[0];
		for (int i = 0; i < INIT_LEN; i++) begin
			if (INIT_TABLE[i].kind != INIT_DELAY) begin
				exp_data = (INIT_TABLE[i].kind == INIT_CMD) ?
					{8'h00, INIT_TABLE[i].value[7:0]} : INIT_TABLE[i].value;
				compare_word(k, INIT_TABLE[i].kind == INIT_DATA, exp_data, f0);
				k++;
			end
		end
		assert (mon.cap_time[0] - rst_rise >= time'(RST_WAIT_MS * MS_CYCLES * CLK_PERIOD))
			else abort_run("First panel word came too soon after panel reset");
		next_word  = k;
		next_frame = f0 + 1;
	endtask

	task automatic measure_pauses();
		int  k = 0;
		time gap;
		time min_gap;
		for (int i = 0; i < INIT_LEN; i++) begin
			if (INIT_TABLE[i].kind == INIT_DELAY) begin
				gap     = mon.cap_time[k] - mon.cap_time[k - 1]; // WR edges around the pause
				min_gap = time'(int'(INIT_TABLE[i].value) * MS_CYCLES * CLK_PERIOD);
				assert (gap >= min_gap)
					else abort_run($sformatf("ERR lcd_wr pause gap expected >= %h got %h",
						min_gap, gap));
			end else begin
				k++;
			end
		end
	endtask

	task automatic write_register();
		host_req_t r;
		r = random_req(1'b1);
		send_req(r);
		match_host_frame(r);
	endtask

	task automatic write_pixel();
		host_req_t r;
		r = random_req(1'b0);
		send_req(r);
		match_host_frame(r);
	endtask

	task automatic stream_requests();
		host_req_t burst[BURST_LEN];
		for (int i = 0; i < BURST_LEN; i++) begin
			burst[i] = random_req(logic'($urandom & 1));
			send_req(burst[i]);
		end
		for (int i = 0; i < BURST_LEN; i++) begin
			match_host_frame(burst[i]);
		end
	endtask

	task automatic expect_bus_idle();
		repeat (20) @(negedge fsm_clk);
		assert (mon.cap_count == next_word) else abort_run("Extra panel words after the last frame");
		assert (lcd_cs == 1'b1) else abort_run($sformatf("ERR lcd_cs expected 1 got %h", lcd_cs));
	endtask

	initial begin
		#(watchdog_cycles() * CLK_PERIOD);
		abort_run("Watchdog expired before the tests finished");
	end

	initial begin
		fsm_rst   = 1'b1;
		req       = '0;
		req_valid = 1'b0;
		void'($urandom(33723));
		verify_reset();
		hold_early_request();
		compare_power_on();
		measure_pauses();
		match_host_frame(held); // Held request comes right after power-on
		write_register();
		write_pixel();
		stream_requests();
		expect_bus_idle();
		if (errors == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("RESULT: FAIL");
			$fatal(1, "Checks failed");
		end
	end

endmodule

// File: bench/panel_bus_monitor.sv
`timescale 1ns/1ps

module panel_bus_monitor import hx8352_pkg::*; (
	input logic      lcd_cs,
	input logic      lcd_wr,
	input logic      lcd_rs,
	input lcd_word_t lcd_data
);
	logic      cap_rs[$];
	lcd_word_t cap_data[$];
	time       cap_time[$];
	int        cap_frame[$];
	int        cap_count = 0;
	int        frame_no  = 0;

	always @(posedge lcd_cs) begin
		frame_no++; // Frame closed
	end

	always @(posedge lcd_wr) begin
		if (lcd_cs === 1'b0) begin // Panel samples on this edge
			cap_rs.push_back(lcd_rs);
			cap_data.push_back(lcd_data);
			cap_time.push_back($time);
			cap_frame.push_back(frame_no);
			cap_count++;
		end
	end

endmodule

// File: hx8352_ctrl.f
logic/hx8352_pkg.sv
logic/ms_delay_timer.sv
logic/power_on_sequencer.sv
logic/host_write_framer.sv
logic/lcd_bus_writer.sv
logic/hx8352_ctrl.sv
bench/panel_bus_monitor.sv
bench/hx8352_ctrl_tb.sv

// File: logic/host_write_framer.sv
`timescale 1ns/1ps

module host_write_framer import hx8352_pkg::*; (
	input  logic      fsm_clk,
	input  logic      fsm_rst,
	input  host_req_t req,
	input  logic      req_valid,
	input  logic      host_ready,
	output logic      req_ready,
	output bus_word_t host_word,
	output logic      host_valid
);
	host_req_t req_q;
	logic      full;
	logic      phase; // 0 command word, 1 data word

	assign req_ready  = !full;
	assign host_valid = full;

	always_comb begin
		host_word.is_data = phase;
		host_word.last    = phase;
		if (phase) begin
			host_word.word = req_q.data;
		end else if (req_q.is_cmd) begin
			host_word.word = lcd_word_t'(req_q.code);
		end else begin
			host_word.word = lcd_word_t'(CMD_MEM_WRITE);
		end
	end

	always_ff @(posedge fsm_clk or posedge fsm_rst) begin
		if (fsm_rst) begin
			full  <= 1'b0;
			phase <= 1'b0;
		end else if (req_valid && req_ready) begin
			full  <= 1'b1;
			phase <= 1'b0;
		end else if (full && host_ready) begin
			if (phase) begin
				full  <= 1'b0; // Data word taken, slot free
				phase <= 1'b0;
			end else begin
				phase <= 1'b1;
			end
		end
	end

	always_ff @(posedge fsm_clk) begin
		if (req_valid && req_ready) begin
			req_q <= req;
		end
	end

endmodule

// File: logic/hx8352_ctrl.sv
`timescale 1ns/1ps

module hx8352_ctrl import hx8352_pkg::*; (
	input  logic      fsm_clk,
	input  logic      fsm_rst,
	input  host_req_t req,
	input  logic      req_valid,
	output logic      req_ready,
	output logic      init_done,
	output lcd_word_t lcd_data,
	output logic      lcd_rs,
	output logic      lcd_wr,
	output logic      lcd_cs,
	output logic      lcd_rst
);
	bus_word_t init_word;
	logic      init_valid;
	logic      init_ready;
	bus_word_t host_word;
	logic      host_valid;
	logic      host_ready;

	power_on_sequencer u_seq (
		.fsm_clk    (fsm_clk),
		.fsm_rst    (fsm_rst),
		.init_ready (init_ready),
		.lcd_rst    (lcd_rst),
		.init_word  (init_word),
		.init_valid (init_valid)
	);

	host_write_framer u_framer (
		.fsm_clk    (fsm_clk),
		.fsm_rst    (fsm_rst),
		.req        (req),
		.req_valid  (req_valid),
		.host_ready (host_ready),
		.req_ready  (req_ready),
		.host_word  (host_word),
		.host_valid (host_valid)
	);

	lcd_bus_writer u_writer (
		.fsm_clk    (fsm_clk),
		.fsm_rst    (fsm_rst),
		.init_word  (init_word),
		.init_valid (init_valid),
		.host_word  (host_word),
		.host_valid (host_valid),
		.init_ready (init_ready),
		.host_ready (host_ready),
		.init_done  (init_done),
		.lcd_data   (lcd_data),
		.lcd_rs     (lcd_rs),
		.lcd_wr     (lcd_wr),
		.lcd_cs     (lcd_cs)
	);

endmodule

// File: logic/hx8352_pkg.sv
package hx8352_pkg;

	typedef logic [15:0] lcd_word_t;
	typedef logic [7:0]  cmd_code_t;
	typedef logic [7:0]  ms_count_t;

	typedef struct packed {
		logic      is_data; // RS level
		lcd_word_t word;
		logic      last;    // Closes the CS frame
	} bus_word_t;

	typedef struct packed {
		logic      is_cmd;  // 0 for pixel write
		cmd_code_t code;
		lcd_word_t data;
	} host_req_t;

	typedef enum logic [1:0] {
		INIT_CMD,
		INIT_DATA,
		INIT_DELAY
	} init_kind_e;

	typedef struct packed {
		init_kind_e kind;
		lcd_word_t  value; // Code, data word or ms
	} init_entry_t;

	localparam int MS_CYCLES      = 16; // Scaled for simulation
	localparam int RST_LOW_MS     = 2;
	localparam int RST_WAIT_MS    = 10;
	localparam int WR_LOW_CYCLES  = 2;
	localparam int WR_HIGH_CYCLES = 2;

	typedef logic [$clog2(MS_CYCLES + 1)-1:0]                      ms_pre_t;
	typedef logic [$clog2(WR_LOW_CYCLES + WR_HIGH_CYCLES + 1)-1:0] wr_phase_t;

	localparam cmd_code_t CMD_DISPLAY_MODE    = 8'h01;
	localparam cmd_code_t CMD_COL_START_1     = 8'h02;
	localparam cmd_code_t CMD_COL_START_2     = 8'h03;
	localparam cmd_code_t CMD_COL_END_1       = 8'h04;
	localparam cmd_code_t CMD_COL_END_2       = 8'h05;
	localparam cmd_code_t CMD_ROW_START_1     = 8'h06;
	localparam cmd_code_t CMD_ROW_START_2     = 8'h07;
	localparam cmd_code_t CMD_ROW_END_1       = 8'h08;
	localparam cmd_code_t CMD_ROW_END_2       = 8'h09;
	localparam cmd_code_t CMD_MEM_ACCESS_CTRL = 8'h16;
	localparam cmd_code_t CMD_OSC_CTRL_1      = 8'h17;
	localparam cmd_code_t CMD_POWER_CTRL_1    = 8'h19;
	localparam cmd_code_t CMD_POWER_CTRL_2    = 8'h1a;
	localparam cmd_code_t CMD_POWER_CTRL_3    = 8'h1b;
	localparam cmd_code_t CMD_POWER_CTRL_4    = 8'h1c;
	localparam cmd_code_t CMD_POWER_CTRL_6    = 8'h1e;
	localparam cmd_code_t CMD_VCOM_CTRL       = 8'h1f;
	localparam cmd_code_t CMD_MEM_WRITE       = 8'h22;
	localparam cmd_code_t CMD_DISPLAY_CTRL_2  = 8'h24;
	localparam cmd_code_t CMD_CYCLE_CTRL_1    = 8'h2b;
	localparam cmd_code_t CMD_CYCLE_CTRL_10   = 8'h34;
	localparam cmd_code_t CMD_CYCLE_CTRL_11   = 8'h35;
	localparam cmd_code_t CMD_SOURCE_CTRL_2   = 8'h3d;
	localparam cmd_code_t CMD_GAMMA_CTRL_1    = 8'h3e;
	localparam cmd_code_t CMD_GAMMA_CTRL_2    = 8'h3f;
	localparam cmd_code_t CMD_GAMMA_CTRL_3    = 8'h40;
	localparam cmd_code_t CMD_GAMMA_CTRL_5    = 8'h42;
	localparam cmd_code_t CMD_GAMMA_CTRL_6    = 8'h43;
	localparam cmd_code_t CMD_GAMMA_CTRL_7    = 8'h44;
	localparam cmd_code_t CMD_GAMMA_CTRL_8    = 8'h45;
	localparam cmd_code_t CMD_GAMMA_CTRL_9    = 8'h46;
	localparam cmd_code_t CMD_GAMMA_CTRL_10   = 8'h47;
	localparam cmd_code_t CMD_GAMMA_CTRL_11   = 8'h48;
	localparam cmd_code_t CMD_GAMMA_CTRL_12   = 8'h49;
	localparam cmd_code_t CMD_PANEL_CTRL      = 8'h55;
	localparam cmd_code_t CMD_TEST_MODE       = 8'h83;
	localparam cmd_code_t CMD_VDDD_CTRL       = 8'h85;
	localparam cmd_code_t CMD_VGS_RES_CTRL_1  = 8'h8b;
	localparam cmd_code_t CMD_VGS_RES_CTRL_2  = 8'h8c;
	localparam cmd_code_t CMD_PWM_CTRL_0      = 8'h91;

	function automatic init_entry_t init_cmd(cmd_code_t code);
		return '{kind: INIT_CMD, value: lcd_word_t'(code)};
	endfunction

	function automatic init_entry_t init_data(lcd_word_t value);
		return '{kind: INIT_DATA, value: value};
	endfunction

	function automatic init_entry_t init_delay(ms_count_t ms);
		return '{kind: INIT_DELAY, value: lcd_word_t'(ms)};
	endfunction

	localparam int INIT_LEN = 94;

	typedef logic [$clog2(INIT_LEN)-1:0] init_idx_t;

	localparam init_entry_t INIT_TABLE [INIT_LEN] = '{
		init_cmd(CMD_TEST_MODE),       init_data(16'h02), // Test mode on
		init_cmd(CMD_VDDD_CTRL),       init_data(16'h03),
		init_cmd(CMD_VGS_RES_CTRL_1),  init_data(16'h01),
		init_cmd(CMD_VGS_RES_CTRL_2),  init_data(16'h93),
		init_cmd(CMD_PWM_CTRL_0),      init_data(16'h01),
		init_cmd(CMD_TEST_MODE),       init_data(16'h00),
		init_cmd(CMD_GAMMA_CTRL_1),    init_data(16'hb0), // Gamma curve
		init_cmd(CMD_GAMMA_CTRL_2),    init_data(16'h03),
		init_cmd(CMD_GAMMA_CTRL_3),    init_data(16'h10),
		init_cmd(CMD_GAMMA_CTRL_5),    init_data(16'h13),
		init_cmd(CMD_GAMMA_CTRL_6),    init_data(16'h46),
		init_cmd(CMD_GAMMA_CTRL_7),    init_data(16'h23),
		init_cmd(CMD_GAMMA_CTRL_8),    init_data(16'h76),
		init_cmd(CMD_GAMMA_CTRL_9),    init_data(16'h00),
		init_cmd(CMD_GAMMA_CTRL_10),   init_data(16'h5e),
		init_cmd(CMD_GAMMA_CTRL_11),   init_data(16'h4f),
		init_cmd(CMD_GAMMA_CTRL_12),   init_data(16'h40),
		init_cmd(CMD_OSC_CTRL_1),      init_data(16'h91), // Power on
		init_cmd(CMD_CYCLE_CTRL_1),    init_data(16'hf9),
		init_delay(8'd10),
		init_cmd(CMD_POWER_CTRL_3),    init_data(16'h14),
		init_cmd(CMD_POWER_CTRL_2),    init_data(16'h11),
		init_cmd(CMD_POWER_CTRL_4),    init_data(16'h06),
		init_cmd(CMD_VCOM_CTRL),       init_data(16'h42),
		init_delay(8'd20),
		init_cmd(CMD_POWER_CTRL_1),    init_data(16'h0a),
		init_cmd(CMD_POWER_CTRL_1),    init_data(16'h1a),
		init_delay(8'd60),
		init_cmd(CMD_POWER_CTRL_1),    init_data(16'h12),
		init_delay(8'd40),
		init_cmd(CMD_POWER_CTRL_6),    init_data(16'h27),
		init_delay(8'd100),
		init_cmd(CMD_DISPLAY_CTRL_2),  init_data(16'h60), // Display on
		init_cmd(CMD_SOURCE_CTRL_2),   init_data(16'h40),
		init_cmd(CMD_CYCLE_CTRL_10),   init_data(16'h38),
		init_cmd(CMD_CYCLE_CTRL_11),   init_data(16'h38),
		init_cmd(CMD_DISPLAY_CTRL_2),  init_data(16'h38),
		init_delay(8'd40),
		init_cmd(CMD_DISPLAY_CTRL_2),  init_data(16'h3c),
		init_cmd(CMD_MEM_ACCESS_CTRL), init_data(16'h1c),
		init_cmd(CMD_DISPLAY_MODE),    init_data(16'h06),
		init_cmd(CMD_PANEL_CTRL),      init_data(16'h00),
		init_cmd(CMD_COL_START_1),     init_data(16'h00), // Window 240 x 400
		init_cmd(CMD_COL_START_2),     init_data(16'h00),
		init_cmd(CMD_COL_END_1),       init_data(16'h00),
		init_cmd(CMD_COL_END_2),       init_data(16'hef),
		init_cmd(CMD_ROW_START_1),     init_data(16'h00),
		init_cmd(CMD_ROW_START_2),     init_data(16'h00),
		init_cmd(CMD_ROW_END_1),       init_data(16'h01),
		init_cmd(CMD_ROW_END_2),       init_data(16'h8f)
	};

endpackage

// File: logic/lcd_bus_writer.sv
`timescale 1ns/1ps

module lcd_bus_writer import hx8352_pkg::*; (
	input  logic      fsm_clk,
	input  logic      fsm_rst,
	input  bus_word_t init_word,
	input  logic      init_valid,
	input  bus_word_t host_word,
	input  logic      host_valid,
	output logic      init_ready,
	output logic      host_ready,
	output logic      init_done,
	output lcd_word_t lcd_data,
	output logic      lcd_rs,
	output logic      lcd_wr,
	output logic      lcd_cs
);
	typedef enum logic [2:0] {
		IDLE,
		CS_SETUP,
		WR_LOW,
		WR_HIGH,
		CS_HOLD
	} wr_state_e;

	wr_state_e state;
	wr_phase_t cnt;
	logic      gnt_host; // Source owning the open frame
	logic      sel_host;
	logic      take;
	logic      last_q;
	bus_word_t sel_word;

	// Between frames the init source wins until init_done
	assign sel_host   = lcd_cs ? init_done : gnt_host;
	assign init_ready = (state == IDLE) && !sel_host;
	assign host_ready = (state == IDLE) && sel_host;
	assign sel_word   = sel_host ? host_word : init_word;
	assign take       = (init_valid && init_ready) || (host_valid && host_ready);

	always_ff @(posedge fsm_clk or posedge fsm_rst) begin
		if (fsm_rst) begin
			state     <= IDLE;
			cnt       <= '0;
			gnt_host  <= 1'b0;
			init_done <= 1'b0;
			lcd_rs    <= 1'b0;
			lcd_wr    <= 1'b1;
			lcd_cs    <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					if (take) begin
						lcd_rs <= sel_word.is_data;
						cnt    <= '0;
						if (lcd_cs) begin
							lcd_cs   <= 1'b0; // Open frame, setup cycle first
							gnt_host <= sel_host;
							state    <= CS_SETUP;
						end else begin
							lcd_wr <= 1'b0;
							state  <= WR_LOW;
						end
					end
				end
				CS_SETUP: begin
					lcd_wr <= 1'b0;
					state  <= WR_LOW;
				end
				WR_LOW: begin
					if (cnt == wr_phase_t'(WR_LOW_CYCLES - 1)) begin
						cnt    <= '0;
						lcd_wr <= 1'b1; // Panel samples here
						state  <= WR_HIGH;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				WR_HIGH: begin
					if (cnt == wr_phase_t'(WR_HIGH_CYCLES - 1)) begin
						cnt <= '0;
						if (last_q) begin
							state <= CS_HOLD;
							if (!gnt_host) begin
								init_done <= 1'b1;
							end
						end else begin
							state <= IDLE;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				CS_HOLD: begin
					lcd_cs <= 1'b1;
					state  <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge fsm_clk) begin
		if (take) begin
			lcd_data <= sel_word.word;
			last_q   <= sel_word.last;
		end
	end

endmodule

// File: logic/ms_delay_timer.sv
`timescale 1ns/1ps

module ms_delay_timer import hx8352_pkg::*; (
	input  logic      fsm_clk,
	input  logic      fsm_rst,
	input  logic      start,
	input  ms_count_t ms,
	output logic      done
);
	ms_pre_t   pre_cnt;
	ms_count_t ms_left;
	logic      busy;

	assign done = !busy;

	always_ff @(posedge fsm_clk or posedge fsm_rst) begin
		if (fsm_rst) begin
			busy    <= 1'b0;
			pre_cnt <= '0;
			ms_left <= '0;
		end else if (start) begin
			pre_cnt <= '0;
			ms_left <= ms;
			busy    <= (ms != '0); // Zero length stays done
		end else if (busy) begin
			if (pre_cnt == ms_pre_t'(MS_CYCLES - 1)) begin
				pre_cnt <= '0;
				ms_left <= ms_left - 1'b1;
				if (ms_left == ms_count_t'(1)) begin
					busy <= 1'b0;
				end
			end else begin
				pre_cnt <= pre_cnt + 1'b1;
			end
		end
	end

endmodule

// File: logic/power_on_sequencer.sv
`timescale 1ns/1ps

module power_on_sequencer import hx8352_pkg::*; (
	input  logic      fsm_clk,
	input  logic      fsm_rst,
	input  logic      init_ready,
	output logic      lcd_rst,
	output bus_word_t init_word,
	output logic      init_valid
);
	typedef enum logic [2:0] {
		RESET_LOW,
		RESET_WAIT,
		RUN,
		PAUSE,
		FINISHED
	} seq_state_e;

	seq_state_e  state;
	init_idx_t   idx;
	init_entry_t entry;
	logic        load_word;
	logic        tmr_start;
	ms_count_t   tmr_ms;
	logic        tmr_done;
	logic        tmr_expired;

	assign entry       = INIT_TABLE[idx];
	assign load_word   = (state == RUN) && !init_valid && (entry.kind != INIT_DELAY);
	assign tmr_expired = !tmr_start && tmr_done; // Start pulse already seen by timer

	ms_delay_timer u_timer (
		.fsm_clk (fsm_clk),
		.fsm_rst (fsm_rst),
		.start   (tmr_start),
		.ms      (tmr_ms),
		.done    (tmr_done)
	);

	always_ff @(posedge fsm_clk or posedge fsm_rst) begin
		if (fsm_rst) begin
			state      <= RESET_LOW;
			idx        <= '0;
			lcd_rst    <= 1'b0;
			init_valid <= 1'b0;
			tmr_start  <= 1'b1; // Reset low phase starts at once
			tmr_ms     <= ms_count_t'(RST_LOW_MS);
		end else begin
			tmr_start <= 1'b0;
			case (state)
				RESET_LOW: begin
					if (tmr_expired) begin
						lcd_rst   <= 1'b1;
						tmr_start <= 1'b1;
						tmr_ms    <= ms_count_t'(RST_WAIT_MS);
						state     <= RESET_WAIT;
					end
				end
				RESET_WAIT: begin
					if (tmr_expired) begin
						state <= RUN;
					end
				end
				RUN: begin
					if (init_valid) begin
						if (init_ready) begin
							init_valid <= 1'b0;
							if (idx == init_idx_t'(INIT_LEN - 1)) begin
								state <= FINISHED;
							end else begin
								idx <= idx + 1'b1;
							end
						end
					end else if (entry.kind == INIT_DELAY) begin
						tmr_start <= 1'b1;
						tmr_ms    <= ms_count_t'(entry.value);
						state     <= PAUSE;
					end else begin
						init_valid <= 1'b1;
					end
				end
				PAUSE: begin
					if (tmr_expired) begin
						idx   <= idx + 1'b1;
						state <= RUN;
					end
				end
				default: begin
					state <= FINISHED; // Sequence played, stays here
				end
			endcase
		end
	end

	always_ff @(posedge fsm_clk) begin
		if (load_word) begin
			init_word.is_data <= (entry.kind == INIT_DATA);
			init_word.word    <= entry.value;
			init_word.last    <= (idx == init_idx_t'(INIT_LEN - 1));
		end
	end

endmodule
